//--- logic/spi_apb_regs.sv
`timescale 1ns/10ps

module spi_apb_regs (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [7:0]                paddr,
	input  spi_flash_pkg::data_t      pwdata,
	output spi_flash_pkg::data_t      prdata,
	output logic                      pready,
	output logic                      pslverr,
	input  logic                      busy,
	input  logic                      frame_end,
	input  spi_flash_pkg::data_t      rx_word,
	output spi_flash_pkg::cmd_t       cmd,
	output spi_flash_pkg::addr_t      addr,
	output spi_flash_pkg::data_t      wdata,
	output spi_flash_pkg::frame_kind_e kind,
	output spi_flash_pkg::nbits_t     nbits,
	output spi_flash_pkg::dummy_t     dummy,
	output logic                      start
);

	import spi_flash_pkg::*;

	logic  wr_en;
	logic  done;
	data_t rdata;

	assign wr_en = psel & penable & pwrite;

	// Zero wait states, no error responses
	assign pready  = 1'b1;
	assign pslverr = 1'b0;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cmd   <= '0;
			addr  <= '0;
			wdata <= '0;
			kind  <= kind_cmd;
			nbits <= nbits_t'(32);
			dummy <= '0;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			if (wr_en) begin
				case (paddr)
					reg_cmd:   cmd   <= pwdata[$bits(cmd_t)-1:0];
					reg_addr:  addr  <= pwdata[$bits(addr_t)-1:0];
					reg_wdata: wdata <= pwdata;
					reg_ctrl: begin
						kind  <= frame_kind_e'(pwdata[ctrl_kind_lsb +: 3]);
						nbits <= pwdata[ctrl_nbits_lsb +: $bits(nbits_t)];
						dummy <= pwdata[ctrl_dummy_lsb +: $bits(dummy_t)];
						// A start during a running frame is dropped
						start <= pwdata[ctrl_start_bit] & ~busy & ~start;
					end
					default: ;
				endcase
			end
		end
	end

	// Done flag and read result
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			done  <= 1'b0;
			rdata <= '0;
		end else if (frame_end) begin
			done  <= 1'b1;
			rdata <= rx_word;
		end else if (start) begin
			done  <= 1'b0;
		end
	end

	always_comb begin
		prdata = '0;
		case (paddr)
			reg_cmd:    prdata = data_t'(cmd);
			reg_addr:   prdata = data_t'(addr);
			reg_wdata:  prdata = wdata;
			reg_ctrl:   prdata = data_t'({dummy, nbits, kind});
			reg_status: prdata = data_t'({done, busy | start});
			reg_rdata:  prdata = rdata;
			default:    prdata = '0;
		endcase
	end

	// Controller must never see a start while a frame runs
	a_no_start_busy: assert property (@(posedge clk) disable iff (rst) !(start && busy));

endmodule

//--- logic/spi_flash_master.sv
`timescale 1ns/10ps

module spi_flash_master #(
	parameter int clks_per_half_sclk = spi_flash_pkg::clks_per_half_sclk_default
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  logic [7:0]           paddr,
	input  spi_flash_pkg::data_t pwdata,
	output spi_flash_pkg::data_t prdata,
	output logic                 pready,
	output logic                 pslverr,
	output logic                 sclk,
	output logic                 ss_n,
	output logic                 mosi,
	input  logic                 miso
);

	import spi_flash_pkg::*;

	cmd_t        cmd;
	addr_t       addr;
	data_t       wdata;
	data_t       rx_word;
	frame_kind_e kind;
	nbits_t      nbits;
	dummy_t      dummy;
	frame_bits_t total_cycles;
	logic        start;
	logic        busy;
	logic        frame_end;
	logic        load;
	logic        run;
	logic        launch;
	logic        sample;
	logic        sclk_done;

	spi_apb_regs regs0 (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.busy(busy), .frame_end(frame_end), .rx_word(rx_word),
		.cmd(cmd), .addr(addr), .wdata(wdata), .kind(kind),
		.nbits(nbits), .dummy(dummy), .start(start)
	);

	spi_frame_ctrl ctrl0 (
		.clk(clk), .rst(rst), .start(start),
		.kind(kind), .nbits(nbits), .dummy(dummy), .sclk_done(sclk_done),
		.busy(busy), .frame_end(frame_end), .ss_n(ss_n),
		.load(load), .run(run), .total_cycles(total_cycles)
	);

	spi_sclk_gen #(.clks_per_half_sclk(clks_per_half_sclk)) sclk0 (
		.clk(clk), .rst(rst), .run(run), .total_cycles(total_cycles),
		.sclk(sclk), .launch(launch), .sample(sample), .sclk_done(sclk_done)
	);

	spi_shift_engine shift0 (
		.clk(clk), .rst(rst), .load(load), .launch(launch), .sample(sample),
		.cmd(cmd), .addr(addr), .wdata(wdata), .kind(kind),
		.nbits(nbits), .dummy(dummy), .miso(miso),
		.mosi(mosi), .rx_word(rx_word)
	);

endmodule

//--- logic/spi_flash_pkg.sv
package spi_flash_pkg;

	typedef logic [7:0]  cmd_t;        // Flash opcode
	typedef logic [23:0] addr_t;       // Flash byte address
	typedef logic [31:0] data_t;
	typedef logic [5:0]  nbits_t;      // 1 to 32
	typedef logic [3:0]  dummy_t;
	typedef logic [6:0]  frame_bits_t; // SCLK cycles per frame

	typedef enum logic [2:0] {
		kind_cmd        = 3'd0,
		kind_cmd_read   = 3'd1,
		kind_addr_read  = 3'd2,
		kind_cmd_write  = 3'd3,
		kind_addr_write = 3'd4,
		kind_cmd_addr   = 3'd5
	} frame_kind_e;

	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_transfer
	} master_state_e;

	// APB register map
	localparam logic [7:0] reg_cmd    = 8'h00;
	localparam logic [7:0] reg_addr   = 8'h04;
	localparam logic [7:0] reg_wdata  = 8'h08;
	localparam logic [7:0] reg_ctrl   = 8'h0C;
	localparam logic [7:0] reg_status = 8'h10;
	localparam logic [7:0] reg_rdata  = 8'h14;

	// Control register fields
	localparam int ctrl_kind_lsb  = 0;
	localparam int ctrl_nbits_lsb = 3;
	localparam int ctrl_dummy_lsb = 9;
	localparam int ctrl_start_bit = 31;

	// SPI mode 3
	localparam bit spi_cpol = 1'b1;
	localparam bit spi_cpha = 1'b1;

	localparam int clks_per_half_sclk_default = 2;

	// Frame kind decoding, codes 6 and 7 fall through as command only
	function automatic logic kind_has_addr(frame_kind_e kind);
		return kind inside {kind_addr_read, kind_addr_write, kind_cmd_addr};
	endfunction

	function automatic logic kind_has_dummy(frame_kind_e kind);
		return kind inside {kind_addr_read, kind_addr_write};
	endfunction

	function automatic logic kind_is_read(frame_kind_e kind);
		return kind inside {kind_cmd_read, kind_addr_read};
	endfunction

	function automatic logic kind_is_write(frame_kind_e kind);
		return kind inside {kind_cmd_write, kind_addr_write};
	endfunction

endpackage

//--- logic/spi_frame_ctrl.sv
`timescale 1ns/10ps

module spi_frame_ctrl (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       start,
	input  spi_flash_pkg::frame_kind_e kind,
	input  spi_flash_pkg::nbits_t      nbits,
	input  spi_flash_pkg::dummy_t      dummy,
	input  logic                       sclk_done,
	output logic                       busy,
	output logic                       frame_end,
	output logic                       ss_n,
	output logic                       load,
	output logic                       run,
	output spi_flash_pkg::frame_bits_t total_cycles
);

	import spi_flash_pkg::*;

	master_state_e state;
	frame_bits_t   cycles;

	// Frame length from the kind and the field values
	always_comb begin
		cycles = frame_bits_t'(8);
		if (kind_has_addr(kind))
			cycles = cycles + frame_bits_t'(24);
		if (kind_has_dummy(kind))
			cycles = cycles + frame_bits_t'(dummy);
		if (kind_is_read(kind) || kind_is_write(kind))
			cycles = cycles + frame_bits_t'(nbits);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state        <= st_idle;
			ss_n         <= 1'b1;
			frame_end    <= 1'b0;
			total_cycles <= '0;
		end else begin
			frame_end <= 1'b0;
			case (state)
				st_idle: begin
					if (start) begin
						total_cycles <= cycles; // Ready for the divider before run
						state        <= st_setup;
					end
				end
				st_setup: begin
					ss_n  <= 1'b0;
					state <= st_transfer;
				end
				st_transfer: begin
					if (sclk_done) begin
						ss_n      <= 1'b1;
						frame_end <= 1'b1;
						state     <= st_idle;
					end
				end
				default: begin
					ss_n  <= 1'b1;
					state <= st_idle;
				end
			endcase
		end
	end

	assign busy = (state != st_idle);
	assign load = (state == st_setup);  // Shift engine samples the fields
	assign run  = (state == st_transfer);

	// Slave select follows the transfer state exactly
	a_ss_transfer: assert property (@(posedge clk) disable iff (rst)
		(state == st_transfer) == !ss_n);

endmodule

//--- logic/spi_sclk_gen.sv
`timescale 1ns/10ps

module spi_sclk_gen #(
	parameter int clks_per_half_sclk = spi_flash_pkg::clks_per_half_sclk_default
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       run,
	input  spi_flash_pkg::frame_bits_t total_cycles,
	output logic                       sclk,
	output logic                       launch,
	output logic                       sample,
	output logic                       sclk_done
);

	import spi_flash_pkg::*;

	localparam int div_w = (clks_per_half_sclk > 1) ? $clog2(clks_per_half_sclk) : 1;

	logic [div_w-1:0] div_cnt;
	frame_bits_t      remain;   // SCLK cycles still to go
	logic             edge_now;
	logic             leading;

	assign edge_now = run && (remain != '0) && (div_cnt == div_w'(clks_per_half_sclk - 1));
	assign leading  = (sclk == spi_cpol);

	// Strobes line up with the SCLK toggle
	assign launch = edge_now && (leading == spi_cpha);
	assign sample = edge_now && (leading != spi_cpha);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sclk      <= spi_cpol;
			div_cnt   <= '0;
			remain    <= '0;
			sclk_done <= 1'b0;
		end else begin
			sclk_done <= 1'b0;
			if (!run) begin
				sclk    <= spi_cpol;
				div_cnt <= '0;
				remain  <= total_cycles;
			end else if (edge_now) begin
				div_cnt <= '0;
				sclk    <= ~sclk;
				if (!leading) begin
					remain <= remain - 1'b1;  // Trailing edge closes a cycle
					if (remain == frame_bits_t'(1))
						sclk_done <= 1'b1;
				end
			end else if (remain != '0) begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

//--- logic/spi_shift_engine.sv
`timescale 1ns/10ps

module spi_shift_engine (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       load,
	input  logic                       launch,
	input  logic                       sample,
	input  spi_flash_pkg::cmd_t        cmd,
	input  spi_flash_pkg::addr_t       addr,
	input  spi_flash_pkg::data_t       wdata,
	input  spi_flash_pkg::frame_kind_e kind,
	input  spi_flash_pkg::nbits_t      nbits,
	input  spi_flash_pkg::dummy_t      dummy,
	input  logic                       miso,
	output logic                       mosi,
	output spi_flash_pkg::data_t       rx_word
);

	import spi_flash_pkg::*;

	logic [31:0] hdr_sr;      // Command then address, MSB first
	data_t       data_sr;     // Write data, left aligned
	logic [5:0]  hdr_left;
	dummy_t      dummy_left;
	logic        data_phase;  // Last launched bit was a data bit
	logic        rd_frame;

	// Phase tracking and MOSI
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mosi       <= 1'b0;
			hdr_left   <= '0;
			dummy_left <= '0;
			data_phase <= 1'b0;
			rd_frame   <= 1'b0;
		end else if (load) begin
			mosi       <= 1'b0;
			hdr_left   <= kind_has_addr(kind) ? 6'd32 : 6'd8;
			dummy_left <= kind_has_dummy(kind) ? dummy : '0;
			data_phase <= 1'b0;
			rd_frame   <= kind_is_read(kind);
		end else if (launch) begin
			if (hdr_left != '0) begin
				mosi     <= hdr_sr[31];
				hdr_left <= hdr_left - 1'b1;
			end else if (dummy_left != '0) begin
				mosi       <= 1'b0;
				dummy_left <= dummy_left - 1'b1;
			end else begin
				mosi       <= data_sr[31]; // Zero for read frames
				data_phase <= 1'b1;
			end
		end
	end

	// Shift registers
	always_ff @(posedge clk) begin
		if (load) begin
			hdr_sr  <= {cmd, addr};
			data_sr <= kind_is_write(kind) ? (wdata << (6'd32 - nbits)) : '0;
			rx_word <= '0;
		end else begin
			if (launch) begin
				if (hdr_left != '0)
					hdr_sr <= hdr_sr << 1;
				else if (dummy_left == '0)
					data_sr <= data_sr << 1;
			end
			// Exactly nbits samples land here, so the word ends right aligned
			if (sample && data_phase && rd_frame)
				rx_word <= {rx_word[30:0], miso};
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the SPI flash master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f spi_flash_master.f --top-module tb_spi_flash_master

./obj_dir/Vtb_spi_flash_master | tee sim.log

grep -q '^\*\* PASS \*\*$' sim.log

//--- sim/spi_frame_cases.txt
// kind cmd addr wdata nbits dummy response, all hex
// kind 0 cmd, 1 cmd+read, 2 addr+dummy+read, 3 cmd+write, 4 addr+dummy+write, 5 cmd+addr
0 06 000000 00000000 08 0 00000000
5 20 012345 00000000 08 0 00000000
1 9f 000000 00000000 18 0 00ef4018
2 0b abcdef 00000000 20 8 deadbeef
3 01 000000 000000a5 08 0 00000000
4 02 100200 cafef00d 20 4 00000000
1 05 000000 00000000 01 0 00000003
2 03 7fffff 00000000 01 2 fffffffe
3 31 000000 ffffffff 01 0 00000000
4 32 0a0b0c 12345678 01 3 00000000
3 aa 000000 87654321 20 0 00000000
2 eb 55aa55 00000000 0d f 1234abcd
7 c7 000000 00000000 08 0 00000000
1 4b 000000 00000000 20 0 a5a5c3c3

//--- sim/tb_spi_flash_master.sv
`timescale 1ns/10ps

module tb_spi_flash_master;

	import spi_flash_pkg::*;

	localparam int half_sclk  = clks_per_half_sclk_default;
	localparam int num_cases  = 14;
	localparam int case_words = 7;  // kind, cmd, addr, wdata, nbits, dummy, response

	logic        clk;
	logic        rst;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        sclk;
	logic        ss_n;
	logic        mosi;
	logic        miso;

	logic [31:0] cases [0:num_cases*case_words-1];
	bit          exp_bits[$];
	logic        seen_bits [0:127];  // MOSI as the flash saw it
	int          bit_cnt = 0;
	int          frame_cnt = 0;
	int          errors = 0;
	int          checks = 0;
	int          cycle_cnt = 0;
	int          cycle_limit = 0;
	logic [31:0] cur_resp = '0;
	int          cur_nbits = 0;
	int          rd_first = -1;     // First read cycle of the frame or -1

	spi_flash_master #(.clks_per_half_sclk(half_sclk)) dut0 (
		.clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .sclk(sclk), .ss_n(ss_n), .mosi(mosi), .miso(miso)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Watchdog
	initial begin
		@(posedge clk);
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: the run went past %0d clock cycles", cycle_limit);
		$display("** FAIL **");
		$finish;
	end

	// Flash slave model in SPI mode 3
	always @(negedge ss_n) begin
		if (!rst) begin
			bit_cnt = 0;
			frame_cnt++;
		end
	end

	always @(posedge sclk) begin
		if (!rst) begin
			if (ss_n) begin
				errors++;
				$display("SCLK rose while ss_n was high");
			end else if (bit_cnt < 128) begin
				seen_bits[bit_cnt] = mosi;
				bit_cnt++;
			end
		end
	end

	always @(negedge sclk) begin
		if (!ss_n && rd_first >= 0 && bit_cnt >= rd_first)
			miso = cur_resp[cur_nbits - 1 - (bit_cnt - rd_first)];
		else
			miso = 1'b1;  // Pulled up outside the read phase
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// Zero wait states and no error responses
	task automatic verify_apb_response();
		check_value("pready", pready, 32'h1);
		check_value("pslverr", pslverr, 32'h0);
	endtask

	task automatic write_reg(input logic [7:0] a, input logic [31:0] d);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = a;
		pwdata  = d;
		@(negedge clk);
		penable = 1'b1;
		verify_apb_response();
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] a, output logic [31:0] d);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = a;
		@(negedge clk);
		penable = 1'b1;
		d       = prdata;  // Settled since the setup cycle
		verify_apb_response();
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// SCLK cycles per frame where codes 6 and 7 count as command only
	function automatic int frame_cycles(input logic [2:0] kind, input int nbits,
			input int dummy);
		case (kind)
			3'd1, 3'd3: return 8 + nbits;
			3'd2, 3'd4: return 32 + dummy + nbits;
			3'd5:       return 32;
			default:    return 8;
		endcase
	endfunction

	task automatic build_stream(input logic [2:0] kind, input logic [7:0] cmd,
			input logic [23:0] addr, input logic [31:0] wdata, input int nbits,
			input int dummy);
		exp_bits.delete();
		for (int b = 7; b >= 0; b--)
			exp_bits.push_back(cmd[b]);
		if (kind == 3'd2 || kind == 3'd4 || kind == 3'd5)
			for (int b = 23; b >= 0; b--)
				exp_bits.push_back(addr[b]);
		if (kind == 3'd2 || kind == 3'd4)
			for (int b = 0; b < dummy; b++)
				exp_bits.push_back(1'b0);
		if (kind == 3'd3 || kind == 3'd4)
			for (int b = nbits - 1; b >= 0; b--)
				exp_bits.push_back(wdata[b]);
		if (kind == 3'd1 || kind == 3'd2)
			for (int b = 0; b < nbits; b++)
				exp_bits.push_back(1'b0);  // MOSI low while reading
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] ctrl;
		logic [31:0] mask;
		logic [2:0]  kind;
		int          base;
		int          nbits;
		int          dummy;
		int          limit;

		void'($urandom(32'h8be6));
		rst     = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		miso    = 1'b1;
		$readmemh("sim/spi_frame_cases.txt", cases);
		limit = 10;
		for (int i = 0; i < num_cases; i++) begin
			base  = i * case_words;
			limit += frame_cycles(cases[base][2:0], cases[base+4], cases[base+5])
				* 2 * half_sclk + 50;
		end
		cycle_limit = limit;

		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_value("ss_n", ss_n, 32'h1);
		check_value("sclk", sclk, 32'h1);
		check_value("mosi", mosi, 32'h0);
		read_reg(reg_status, rd);
		check_value("reg_status", rd, 32'h0);

		for (int i = 0; i < num_cases; i++) begin
			base  = i * case_words;
			kind  = cases[base][2:0];
			nbits = cases[base+4];
			dummy = cases[base+5];
			build_stream(kind, cases[base+1][7:0], cases[base+2][23:0], cases[base+3],
				nbits, dummy);
			cur_resp  = cases[base+6];
			cur_nbits = nbits;
			rd_first  = (kind == 3'd1 || kind == 3'd2) ? exp_bits.size() - nbits : -1;

			write_reg(reg_cmd, cases[base+1]);
			write_reg(reg_addr, cases[base+2]);
			write_reg(reg_wdata, cases[base+3]);
			ctrl = '0;
			ctrl[ctrl_start_bit]        = 1'b1;
			ctrl[ctrl_dummy_lsb +: 4]   = cases[base+5][3:0];
			ctrl[ctrl_nbits_lsb +: 6]   = cases[base+4][5:0];
			ctrl[ctrl_kind_lsb +: 3]    = kind;
			write_reg(reg_ctrl, ctrl);
			if (i % 3 == 2) begin
				wait (ss_n == 1'b0);
				repeat (4) @(negedge clk);
				// Second start with other field values lands mid frame
				write_reg(reg_ctrl, ctrl ^ 32'h0000_1fff);
			end

			// Done set and busy clear
			read_reg(reg_status, rd);
			while (rd != 32'h2)
				read_reg(reg_status, rd);

			check_value("sclk cycles", bit_cnt, frame_cycles(kind, nbits, dummy));
			for (int b = 0; b < exp_bits.size() && b < bit_cnt; b++) begin
				checks++;
				if (seen_bits[b] !== exp_bits[b]) begin
					errors++;
					$display("ERROR mosi case %0d bit %0d: got 0x%h, expected 0x%h",
						i, b, seen_bits[b], exp_bits[b]);
				end
			end
			if (rd_first >= 0) begin
				mask = (nbits == 32) ? 32'hffffffff : (32'h1 << nbits) - 32'h1;
				read_reg(reg_rdata, rd);
				check_value("reg_rdata", rd, cur_resp & mask);
			end

			repeat (4 + $urandom % 8) @(negedge clk);
			if (frame_cnt != i + 1) begin
				errors++;
				$display("An extra frame started after case %0d", i);
			end
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- spi_flash_master.f
logic/spi_flash_pkg.sv
logic/spi_sclk_gen.sv
logic/spi_frame_ctrl.sv
logic/spi_shift_engine.sv
logic/spi_apb_regs.sv
logic/spi_flash_master.sv
sim/tb_spi_flash_master.sv
